// ==== verilog/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// clock enables, clk_sys is 40 MHz
`define CEN_DIV 8
`define SOUND_DIV 45

// main program ROM, 4096 bytes
`define ROM_AW 12

// sound sample width
`define DAC_W 8

`endif

// ==== verilog/core_cfg_pkg.sv ====
package core_cfg_pkg;

	// games of the board family, the code is the low bits of core_mod
	typedef enum logic [2:0] {
		qbert    = 3'd0,
		qub      = 3'd1,
		mplanets = 3'd2,
		krull    = 3'd3,
		curvebal = 3'd4,
		tylz     = 3'd5,
		insector = 3'd6
	} game_e;

	// option bits from the host menu
	typedef struct packed {
		logic       reset_req; // host reset entry
		logic       service;   // test mode switch
		logic       diagonal;  // diagonal joystick mode
		logic       joyswap;
		logic [7:0] dip;       // board dip switches
	} core_opts_t;

endpackage

// ==== verilog/player_io_pkg.sv ====
package player_io_pkg;

	// one player's controls, active high
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic up_b;    // second stick
		logic down_b;
		logic left_b;
		logic right_b;
	} player_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
	} controls_t;

	// host download stream
	typedef struct packed {
		logic        download; // high for the whole transfer
		logic [7:0]  index;    // 0 is the program ROM
		logic        wr;       // one byte per rising edge
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_t;

endpackage

// ==== verilog/clock_enables.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module clock_enables (
	input  logic clk_sys,
	input  logic rst_n,
	output logic cpu_clk,
	output logic cen_5,
	output logic cen_10_p,
	output logic cen_10_n,
	output logic sound_cen
);
	localparam int CEN_CW = $clog2(`CEN_DIV);
	localparam int SND_CW = $clog2(`SOUND_DIV);
	localparam logic [CEN_CW-1:0] CEN_LAST = CEN_CW'(`CEN_DIV - 1);
	localparam logic [CEN_CW-1:0] CEN_HALF = CEN_CW'(`CEN_DIV / 2 - 1);
	localparam logic [SND_CW-1:0] SND_LAST = SND_CW'(`SOUND_DIV - 1);

	logic [CEN_CW-1:0] cnt_cen;
	logic [SND_CW-1:0] cnt_snd;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cnt_cen  <= '0;
			cnt_snd  <= '0;
			cpu_clk  <= 1'b0;
			cen_5    <= 1'b0;
			cen_10_p <= 1'b0;
			cen_10_n <= 1'b0;
			sound_cen <= 1'b0;
		end else begin
			if (cnt_cen == CEN_LAST)
				cnt_cen <= '0;
			else
				cnt_cen <= cnt_cen + 1'b1;
			cpu_clk  <= cnt_cen[CEN_CW-1]; // 5 MHz square wave
			cen_5    <= cnt_cen == CEN_LAST;
			cen_10_p <= cnt_cen == CEN_HALF || cnt_cen == CEN_LAST;
			cen_10_n <= cnt_cen == CEN_CW'(1) || cnt_cen == CEN_HALF + CEN_CW'(2); // 1 and 5

			if (cnt_snd == SND_LAST)
				cnt_snd <= '0;
			else
				cnt_snd <= cnt_snd + 1'b1;
			sound_cen <= cnt_snd == SND_LAST;
		end
	end

endmodule

// ==== verilog/rom_loader.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module rom_loader (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  player_io_pkg::ioctl_t ioctl,
	input  logic                  reset_req,
	input  logic [`ROM_AW-1:0]    rom_addr,
	output logic [7:0]            rom_data,
	output logic                  core_reset,
	output logic                  led
);
	localparam int ROM_DEPTH = 1 << `ROM_AW;

	logic [7:0] rom_mem [ROM_DEPTH];

	logic              wr_q;     // sampled strobe
	logic              wr_d;
	logic              in_range;
	logic              prog_dl;
	logic              wr_stb;
	logic [`ROM_AW-1:0] wr_addr;
	logic [7:0]        wr_data;

	logic dl_last;
	logic idx0_last;
	logic rom_loaded;

	assign in_range = ioctl.addr[24:`ROM_AW] == '0;
	assign prog_dl  = ioctl.download && ioctl.index == 8'd0;

	// edge detect on the write strobe
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_q   <= 1'b0;
			wr_d   <= 1'b0;
			wr_stb <= 1'b0;
		end else begin
			wr_q   <= ioctl.wr;
			wr_d   <= wr_q;
			wr_stb <= wr_q && !wr_d && prog_dl && in_range;
		end
	end

	// addr and data hold until the next strobe edge
	always_ff @(posedge clk_sys) begin
		wr_addr <= ioctl.addr[`ROM_AW-1:0];
		wr_data <= ioctl.data;
	end

	always_ff @(posedge clk_sys) begin
		if (wr_stb)
			rom_mem[wr_addr] <= wr_data;
		rom_data <= rom_mem[rom_addr]; // cpu read port
	end

	// hold the core in reset until the program is in
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_last    <= 1'b0;
			idx0_last  <= 1'b0;
			rom_loaded <= 1'b0;
			core_reset <= 1'b1;
			led        <= 1'b1;
		end else begin
			dl_last   <= ioctl.download;
			idx0_last <= ioctl.index == 8'd0;
			if (dl_last && !ioctl.download && idx0_last)
				rom_loaded <= 1'b1;
			core_reset <= reset_req || !rom_loaded;
			led        <= !ioctl.download;
		end
	end

endmodule

// ==== verilog/input_mapper.sv ====
`timescale 1ns/1ps

module input_mapper (
	input  core_cfg_pkg::game_e      game,
	input  core_cfg_pkg::core_opts_t opts,
	input  player_io_pkg::player_t   p1,
	input  player_io_pkg::player_t   p2,
	input  player_io_pkg::controls_t ctrl,
	output logic [7:0]               ip1710,
	output logic [7:0]               ip4740
);
	import core_cfg_pkg::*;
	import player_io_pkg::*;

	player_t pa; // player one after swap
	player_t pb;

	// qbert style stick nibble: down, up, left, right
	function automatic logic [3:0] stick_dirs(player_t p, logic diag);
		if (diag)
			return {p.down & p.left, p.up & p.right, p.left & p.up, p.right & p.down};
		return {p.down, p.up, p.left, p.right};
	endfunction

	assign pa = opts.joyswap ? p2 : p1;
	assign pb = opts.joyswap ? p1 : p2;

	always_comb begin
		ip1710 = {pa.fire_a, ~opts.service, 2'b00,
			ctrl.coin2, ctrl.coin1, ctrl.start2, ctrl.start1};
		ip4740 = {stick_dirs(pb, opts.diagonal), stick_dirs(pa, opts.diagonal)};

		case (game)
			mplanets: begin
				ip1710 = {~opts.service, pa.fire_a, 4'd0, ctrl.coin2, ctrl.coin1};
				ip4740 = {pa.fire_b, ctrl.start2, ctrl.start1, pa.fire_a,
					pa.left, pa.down, pa.right, pa.up};
			end
			krull: begin
				ip1710 = {ctrl.start2, ctrl.start1, 2'b00,
					ctrl.coin2, ctrl.coin1, pa.fire_a, ~opts.service};
				// right stick from player two or the second stick
				ip4740 = {pa.left, pa.down, pa.right, pa.up,
					pb.left | pa.left_b, pb.down | pa.down_b,
					pb.right | pa.right_b, pb.up | pa.up_b};
			end
			curvebal: begin
				ip1710 = {4'd0, ctrl.coin2, ctrl.coin1, pa.fire_a, ~opts.service};
				ip4740 = {1'b0, pa.fire_d | pa.down,  // bunt
					1'b0, pa.fire_c | pa.right,      // pitch right
					1'b0, pa.fire_b | pa.left,       // pitch left
					pa.fire_a | pa.up, 1'b0};        // swing
			end
			tylz: begin
				ip1710 = {4'd0, ctrl.coin1, ctrl.coin2, pa.fire_a, ~opts.service};
				if (opts.diagonal)
					ip4740 = {1'b0, ctrl.start2, ctrl.start1, pa.fire_a,
						pa.left & pa.up, pa.right & pa.up,
						pa.right & pa.down, pa.left & pa.down};
				else
					ip4740 = {1'b0, ctrl.start2, ctrl.start1, pa.fire_a,
						pa.left, pa.up, pa.right, pa.down};
			end
			insector: begin
				ip1710 = {1'b0, ~opts.service, pb.fire_b, pb.fire_a,
					ctrl.coin2, ctrl.coin2, pa.fire_b, pa.fire_a};
				ip4740 = {pb.left, pb.down, pb.right, pb.up,
					pa.left, pa.down, pa.right, pa.up};
			end
			default: ; // qbert layout
		endcase
	end

endmodule

// ==== verilog/audio_dac.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module audio_dac (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic [`DAC_W-1:0] sample,
	output logic              out
);
	logic [`DAC_W-1:0] acc;
	logic [`DAC_W:0]   sum; // carry on top

	assign sum = {1'b0, acc} + {1'b0, sample};

	// first order sigma-delta, ones density is sample / 256
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc <= '0;
			out <= 1'b0;
		end else begin
			acc <= sum[`DAC_W-1:0];
			out <= sum[`DAC_W];
		end
	end

endmodule

// ==== verilog/qbert_core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module qbert_core (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  core_cfg_pkg::game_e      game,
	input  core_cfg_pkg::core_opts_t opts,
	input  player_io_pkg::ioctl_t    ioctl,
	input  player_io_pkg::player_t   p1,
	input  player_io_pkg::player_t   p2,
	input  player_io_pkg::controls_t ctrl,
	input  logic [`ROM_AW-1:0]       rom_addr,
	input  logic [`DAC_W-1:0]        sample,
	output logic [7:0]               rom_data,
	output logic                     core_reset,
	output logic                     led,
	output logic                     cpu_clk,
	output logic                     cen_5,
	output logic                     cen_10_p,
	output logic                     cen_10_n,
	output logic                     sound_cen,
	output logic [7:0]               ip1710,
	output logic [7:0]               ip4740,
	output logic [7:0]               dip,
	output logic                     audio_l,
	output logic                     audio_r
);
	logic audio_out;

	assign dip     = opts.dip;
	assign audio_l = audio_out; // mono dac on both channels
	assign audio_r = audio_out;

	clock_enables clk_en (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.cpu_clk   (cpu_clk),
		.cen_5     (cen_5),
		.cen_10_p  (cen_10_p),
		.cen_10_n  (cen_10_n),
		.sound_cen (sound_cen)
	);

	rom_loader loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.ioctl      (ioctl),
		.reset_req  (opts.reset_req),
		.rom_addr   (rom_addr),
		.rom_data   (rom_data),
		.core_reset (core_reset),
		.led        (led)
	);

	input_mapper mapper (
		.game   (game),
		.opts   (opts),
		.p1     (p1),
		.p2     (p2),
		.ctrl   (ctrl),
		.ip1710 (ip1710),
		.ip4740 (ip4740)
	);

	audio_dac dac (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.sample  (sample),
		.out     (audio_out)
	);

endmodule

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
	output logic clk
);
	// 100 ns period, 10 MHz sim clock for clk_sys
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

// ==== tests/tb_qbert_core.sv ====
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_qbert_core;
	import core_cfg_pkg::*;
	import player_io_pkg::*;

	// rough cycles of reset, clocks, download, ignored writes, mapping and audio
	localparam int RUN_CYCLES = 16 + 450 + 64 * 6 + 24 * 6 + 10 * 8 + 5 * 520;
	localparam int MAX_CYCLES = 2 * RUN_CYCLES;

	logic       clk_sys;
	logic       rst_n;
	game_e      game;
	core_opts_t opts;
	ioctl_t     ioctl;
	player_t    p1;
	player_t    p2;
	controls_t  ctrl;
	logic [`ROM_AW-1:0] rom_addr;
	logic [`DAC_W-1:0]  sample;

	logic [7:0] rom_data;
	logic       core_reset;
	logic       led;
	logic       cpu_clk;
	logic       cen_5;
	logic       cen_10_p;
	logic       cen_10_n;
	logic       sound_cen;
	logic [7:0] ip1710;
	logic [7:0] ip4740;
	logic [7:0] dip;
	logic       audio_l;
	logic       audio_r;

	logic [31:0] rng_state;
	logic [7:0]  rom_model [1 << `ROM_AW]; // expected rom contents
	logic [`ROM_AW-1:0] addr_list [64];
	int cycles = 0;

	clk_gen clock (
		.clk (clk_sys)
	);

	qbert_core UUT (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.game       (game),
		.opts       (opts),
		.ioctl      (ioctl),
		.p1         (p1),
		.p2         (p2),
		.ctrl       (ctrl),
		.rom_addr   (rom_addr),
		.sample     (sample),
		.rom_data   (rom_data),
		.core_reset (core_reset),
		.led        (led),
		.cpu_clk    (cpu_clk),
		.cen_5      (cen_5),
		.cen_10_p   (cen_10_p),
		.cen_10_n   (cen_10_n),
		.sound_cen  (sound_cen),
		.ip1710     (ip1710),
		.ip4740     (ip4740),
		.dip        (dip),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

	function automatic logic [31:0] xorshift32();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic stop_failed;
		$display("Test FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_eq(input string name, input logic [31:0] act, input logic [31:0] exp);
		assert (act === exp) else begin
			$display("ERR %0t ns %s: expected %0h, actual %0h", $time, name, exp, act);
			stop_failed();
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%0t ns: %s", $time, what);
			stop_failed();
		end
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
			stop_failed();
		end
	end

	// port bytes as the cabinet wiring of each game gives them
	function automatic logic [15:0] expect_ports(game_e g, core_opts_t o, player_t q1,
		player_t q2, controls_t c);
		player_t a;
		player_t b;
		logic ns;
		logic [7:0] i1;
		logic [7:0] i4;
		a = o.joyswap ? q2 : q1;
		b = o.joyswap ? q1 : q2;
		ns = ~o.service; // service switch is active low
		case (g)
			mplanets: begin
				i1 = {ns, a.fire_a, 4'b0000, c.coin2, c.coin1};
				i4 = {a.fire_b, c.start2, c.start1, a.fire_a, a.left, a.down, a.right, a.up};
			end
			krull: begin
				i1 = {c.start2, c.start1, 2'b00, c.coin2, c.coin1, a.fire_a, ns};
				i4 = {a.left, a.down, a.right, a.up, b.left | a.left_b, b.down | a.down_b,
					b.right | a.right_b, b.up | a.up_b};
			end
			curvebal: begin
				i1 = {4'b0000, c.coin2, c.coin1, a.fire_a, ns};
				i4 = {1'b0, a.fire_d | a.down, 1'b0, a.fire_c | a.right,
					1'b0, a.fire_b | a.left, a.fire_a | a.up, 1'b0};
			end
			tylz: begin
				i1 = {4'b0000, c.coin1, c.coin2, a.fire_a, ns};
				i4[7:4] = {1'b0, c.start2, c.start1, a.fire_a};
				i4[3:0] = o.diagonal
					? {a.left & a.up, a.right & a.up, a.right & a.down, a.left & a.down}
					: {a.left, a.up, a.right, a.down};
			end
			insector: begin
				i1 = {1'b0, ns, b.fire_b, b.fire_a, c.coin2, c.coin2, a.fire_b, a.fire_a};
				i4 = {b.left, b.down, b.right, b.up, a.left, a.down, a.right, a.up};
			end
			default: begin
				i1 = {a.fire_a, ns, 2'b00, c.coin2, c.coin1, c.start2, c.start1};
				i4 = {b.down, b.up, b.left, b.right, a.down, a.up, a.left, a.right};
				if (o.diagonal)
					i4 = {b.down & b.left, b.up & b.right, b.left & b.up, b.right & b.down,
						a.down & a.left, a.up & a.right, a.left & a.up, a.right & a.down};
			end
		endcase
		return {i1, i4};
	endfunction

	task automatic track_pulse(input string name, input int k, input int gap,
		inout int count, inout int last);
		if (count > 0)
			check_eq(name, k - last, gap);
		count++;
		last = k;
	endtask

	task automatic begin_download(input logic [7:0] idx);
		@(negedge clk_sys);
		ioctl.download = 1'b1;
		ioctl.index = idx;
		ioctl.wr = 1'b0;
	endtask

	task automatic end_download;
		@(negedge clk_sys);
		ioctl.download = 1'b0;
	endtask

	// strobe high two cycles, low two cycles
	task automatic send_byte(input logic [24:0] a, input logic [7:0] d);
		@(negedge clk_sys);
		ioctl.addr = a;
		ioctl.data = d;
		ioctl.wr = 1'b1;
		@(negedge clk_sys);
		check_eq("led", 32'(led), 0);
		@(negedge clk_sys);
		check_eq("led", 32'(led), 0);
		ioctl.wr = 1'b0;
		@(negedge clk_sys);
		check_eq("led", 32'(led), 0);
	endtask

	task automatic read_check(input logic [`ROM_AW-1:0] a);
		@(negedge clk_sys);
		rom_addr = a;
		@(negedge clk_sys);
		check_eq("rom_data", 32'(rom_data), 32'(rom_model[a]));
	endtask

	task automatic test_clock_enables;
		int k;
		int n5, l5, np, lp, nn, ln, nr, lr, ns, lsnd, nhigh;
		logic clk_q;
		n5 = 0;
		l5 = 0;
		np = 0;
		lp = 0;
		nn = 0;
		ln = 0;
		nr = 0;
		lr = 0;
		ns = 0;
		lsnd = 0;
		nhigh = 0;
		clk_q = 1'b0;
		for (k = 1; k <= 450; k++) begin
			@(negedge clk_sys);
			if (k == 1)
				check_eq("cpu_clk/cen_5/cen_10_p/cen_10_n/sound_cen",
					32'({cpu_clk, cen_5, cen_10_p, cen_10_n, sound_cen}), 0);
			if (k <= 80) begin
				check_true(!(cen_10_p && cen_10_n), "cen_10_p and cen_10_n high together");
				if (cen_5)
					track_pulse("cen_5 spacing", k, `CEN_DIV, n5, l5);
				if (cen_10_p)
					track_pulse("cen_10_p spacing", k, `CEN_DIV / 2, np, lp);
				if (cen_10_n)
					track_pulse("cen_10_n spacing", k, `CEN_DIV / 2, nn, ln);
				if (cpu_clk && !clk_q)
					track_pulse("cpu_clk period", k, `CEN_DIV, nr, lr);
				if (cpu_clk)
					nhigh++;
				clk_q = cpu_clk;
			end
			if (sound_cen)
				track_pulse("sound_cen spacing", k, `SOUND_DIV, ns, lsnd);
		end
		check_eq("cen_5 count", n5, 10);
		check_eq("cen_10_p count", np, 20);
		check_eq("cen_10_n count", nn, 20);
		check_eq("cpu_clk rising edges", nr, 10);
		check_eq("cpu_clk high cycles", nhigh, 40);
		check_eq("sound_cen count", ns, 10);
	endtask

	task automatic test_rom_download;
		logic [31:0] r;
		int i;
		int n;
		for (i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			check_eq("core_reset", 32'(core_reset), 1);
		end
		begin_download(8'h00);
		for (i = 0; i < 64; i++) begin
			r = xorshift32();
			addr_list[i] = r[11:0];
			rom_model[r[11:0]] = r[19:12]; // last write to an address wins
			send_byte(25'(r[11:0]), r[19:12]);
		end
		end_download();
		n = 0;
		while (core_reset && n < 3) begin
			@(negedge clk_sys);
			n++;
		end
		check_true(!core_reset, "core_reset still high 3 cycles after the download ended");
		check_eq("led", 32'(led), 1);
		for (i = 0; i < 64; i++)
			read_check(addr_list[i]);
	endtask

	task automatic test_ignored_writes;
		logic [31:0] r;
		int i;
		begin_download(8'hff);
		for (i = 0; i < 8; i++)
			send_byte(25'(addr_list[i]), ~rom_model[addr_list[i]]);
		end_download();
		begin_download(8'h00);
		for (i = 8; i < 16; i++) begin
			r = xorshift32();
			send_byte({r[12:0] | 13'd1, addr_list[i]}, ~rom_model[addr_list[i]]); // above 4 KiB
		end
		end_download();
		for (i = 0; i < 16; i++)
			read_check(addr_list[i]);
		@(negedge clk_sys);
		opts.reset_req = 1'b1;
		@(negedge clk_sys);
		check_eq("core_reset", 32'(core_reset), 1);
		opts.reset_req = 1'b0;
		@(negedge clk_sys);
		check_eq("core_reset", 32'(core_reset), 0);
	endtask

	task automatic check_mapping(input game_e g, input logic diag, input logic swap);
		logic [31:0] r;
		logic [31:0] r2;
		logic [15:0] exp_ports;
		int i;
		for (i = 0; i < 8; i++) begin
			@(negedge clk_sys);
			r = xorshift32();
			r2 = xorshift32();
			game = g;
			p1 = player_t'(r[11:0]);
			p2 = player_t'(r[23:12]);
			ctrl = controls_t'(r[27:24]);
			opts.service = r[28];
			opts.dip = r2[7:0];
			opts.diagonal = diag;
			opts.joyswap = swap;
			@(posedge clk_sys);
			exp_ports = expect_ports(g, opts, p1, p2, ctrl);
			check_eq("ip1710", 32'(ip1710), 32'(exp_ports[15:8]));
			check_eq("ip4740", 32'(ip4740), 32'(exp_ports[7:0]));
			check_eq("dip", 32'(dip), 32'(r2[7:0]));
		end
	endtask

	task automatic test_default_mapping;
		check_mapping(qbert, 1'b0, 1'b0);
		check_mapping(qbert, 1'b1, 1'b0);
		check_mapping(qbert, 1'b0, 1'b1);
		check_mapping(qbert, 1'b1, 1'b1);
	endtask

	task automatic test_game_mapping;
		check_mapping(mplanets, 1'b0, 1'b0);
		check_mapping(krull, 1'b0, 1'b0);
		check_mapping(krull, 1'b0, 1'b1);
		check_mapping(curvebal, 1'b0, 1'b0);
		check_mapping(tylz, 1'b0, 1'b0);
		check_mapping(tylz, 1'b1, 1'b0);
		check_mapping(insector, 1'b0, 1'b0);
	endtask

	task automatic audio_run(input logic [7:0] s);
		int ones;
		int i;
		@(negedge clk_sys);
		sample = s;
		repeat (256) @(negedge clk_sys); // let the accumulator settle
		ones = 0;
		for (i = 0; i < 256; i++) begin
			@(negedge clk_sys);
			check_eq("audio_r", 32'(audio_r), 32'(audio_l));
			if (audio_l)
				ones++;
		end
		check_eq("audio_l ones", ones, 32'(s));
	endtask

	task automatic test_audio;
		logic [31:0] r;
		int i;
		audio_run(8'd0);
		audio_run(8'd255);
		for (i = 0; i < 3; i++) begin
			r = xorshift32();
			audio_run(r[7:0]);
		end
	endtask

	initial begin
		rng_state = 32'd24;
		rst_n = 1'b0;
		game = qbert;
		opts = '0;
		ioctl = '0;
		p1 = '0;
		p2 = '0;
		ctrl = '0;
		rom_addr = '0;
		sample = '0;
		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;
		test_clock_enables();
		test_rom_download();
		test_ignored_writes();
		test_default_mapping();
		test_game_mapping();
		test_audio();
		$display("Test OK");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+verilog
verilog/core_cfg_pkg.sv
verilog/player_io_pkg.sv
verilog/clock_enables.sv
verilog/rom_loader.sv
verilog/input_mapper.sv
verilog/audio_dac.sv
verilog/qbert_core.sv
tests/clk_gen.sv
tests/tb_qbert_core.sv

// ==== Makefile ====
TOP := tb_qbert_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module qbert_core

clean:
	rm -rf obj_dir
